// ==== alu_consts.svh ====
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// ========================================
// datapath sizing
// ========================================
`define DATA_W 32 // word width of registers and alu
`define NREGS 16 // architectural registers, r0 included
`define REG_AW 4 // bits needed to index NREGS

// ========================================
// csr select codes, taken from imm[0]
// ========================================
`define CSR_CYCLE 1'b0 // free-running cycle count
`define CSR_RETIRED 1'b1 // instructions completed so far

`endif

// ==== alu_pkg.sv ====
`default_nettype none

`include "alu_consts.svh"

package alu_pkg;

	typedef logic [`DATA_W-1:0] value_t;

	// ========================================
	// instruction encodings
	// ========================================
	typedef enum logic [5:0] {
		R2 = 6'h00, // register form, operation in func
		ADDI = 6'h04, SUBFI, ANDI, ORI, XORI,
		CMP_EQI = 6'h10, CMP_NEI, CMP_LTI, CMP_GEI, CMP_LEI, CMP_GTI,
		CMP_LTUI, CMP_GEUI, CMP_LEUI, CMP_GTUI,
		FCMP_EQI = 6'h20, FCMP_NEI, FCMP_LTI, FCMP_LEI, FCMP_GTI, FCMP_GEI,
		CSR = 6'h30 // counter read, select in imm
	} opcode_e;

	typedef enum logic [5:0] {
		R1 = 6'h00, // single operand, operation in rb
		ADD = 6'h04, SUB, AND, OR, XOR,
		CMP_EQ = 6'h10, CMP_NE, CMP_LT, CMP_GE, CMP_LE, CMP_GT,
		CMP_LTU, CMP_GEU, CMP_LEU, CMP_GTU,
		FCMP_EQ = 6'h20, FCMP_NE, FCMP_LT, FCMP_LE, FCMP_GT, FCMP_GE,
		SLL = 6'h28, SRL, SRA, SLLI, SRLI, SRAI
	} func_e;

	typedef enum logic [3:0] {
		CNTLZ, CNTPOP, FABS, FNABS, FNEG, FCLASS, FSIGN, FFINITE
	} r1_e;

	typedef struct packed {
		opcode_e opcode;
		logic [`REG_AW-1:0] rd;
		logic [`REG_AW-1:0] ra;
		logic [`REG_AW-1:0] rb; // also r1_e code when func is R1
		func_e func;
		logic [7:0] imm; // sign-extended in the alu
	} instr_t;

	// float classification of one operand
	typedef struct packed {
		logic sign, exp_zero, val_zero, inf, exp_ones, snan, qnan;
	} fp_info_t;

	// float relation flags, ordered ones clear when unord
	typedef struct packed {
		logic eq, lt, le, gt, ge, ne, unord;
	} fcmp_t;

	typedef enum logic [1:0] {IDLE, READ, EXEC, WRITE} ctrl_state_e;

endpackage

`default_nettype wire

// ==== fp_decomp.sv ====
`timescale 1ns/100ps
`default_nettype none

module fp_decomp (
	input  alu_pkg::value_t   i_i,
	output alu_pkg::fp_info_t info_o
);

	logic [7:0] expo;
	logic [22:0] man;
	logic man_zero;
	logic nan;

	assign expo = i_i[30:23]; // biased exponent
	assign man = i_i[22:0];
	assign man_zero = (man == 23'd0);
	assign nan = info_o.exp_ones & ~man_zero;

	assign info_o.sign = i_i[31];
	assign info_o.exp_zero = (expo == 8'h00); // zero or subnormal
	assign info_o.val_zero = info_o.exp_zero & man_zero;
	assign info_o.exp_ones = (expo == 8'hff); // inf or nan
	assign info_o.inf = info_o.exp_ones & man_zero;

	// quiet bit is the top of the mantissa
	assign info_o.snan = nan & ~man[22];
	assign info_o.qnan = nan & man[22];

endmodule

`default_nettype wire

// ==== fp_compare.sv ====
`timescale 1ns/100ps
`default_nettype none

module fp_compare (
	input  alu_pkg::value_t a_i,
	input  alu_pkg::value_t b_i,
	output alu_pkg::fcmp_t  flags_o
);

	alu_pkg::fp_info_t ia, ib;
	logic unord, eq_raw, lt_raw, mag_lt;

	fp_decomp u_dec_a (.i_i(a_i), .info_o(ia));
	fp_decomp u_dec_b (.i_i(b_i), .info_o(ib));

	assign unord = ia.snan | ia.qnan | ib.snan | ib.qnan;
	assign mag_lt = (a_i[30:0] < b_i[30:0]);
	assign eq_raw = (ia.val_zero & ib.val_zero) | (a_i == b_i); // +0 == -0

	always_comb begin
		if (eq_raw)
			lt_raw = 1'b0;
		else if (ia.sign != ib.sign)
			lt_raw = ia.sign; // negative side is smaller
		else if (ia.sign)
			lt_raw = ~mag_lt; // both negative, bigger magnitude is smaller
		else
			lt_raw = mag_lt;
	end

	assign flags_o.eq = ~unord & eq_raw;
	assign flags_o.lt = ~unord & lt_raw;
	assign flags_o.le = ~unord & (lt_raw | eq_raw);
	assign flags_o.gt = ~unord & ~lt_raw & ~eq_raw;
	assign flags_o.ge = ~unord & ~lt_raw;
	assign flags_o.ne = unord | ~eq_raw; // nan is never equal
	assign flags_o.unord = unord;

endmodule

`default_nettype wire

// ==== int_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "alu_consts.svh"

module int_alu (
	input  alu_pkg::instr_t ir_i,
	input  alu_pkg::value_t a_i,
	input  alu_pkg::value_t b_i,
	input  alu_pkg::value_t csr_i,
	output alu_pkg::value_t o_o
);

	alu_pkg::value_t imm, fclass;
	alu_pkg::fp_info_t fa;
	alu_pkg::fcmp_t fc_r, fc_i;
	logic [5:0] lz, pop;
	logic fa_normal;

	// compare result widened to a word
	function automatic alu_pkg::value_t b2v(input logic b);
		return {{(`DATA_W-1){1'b0}}, b};
	endfunction

	assign imm = {{(`DATA_W-8){ir_i.imm[7]}}, ir_i.imm};

	fp_decomp u_dec (.i_i(a_i), .info_o(fa));
	fp_compare u_fcmp_r (.a_i(a_i), .b_i(b_i), .flags_o(fc_r)); // register form
	fp_compare u_fcmp_i (.a_i(a_i), .b_i(imm), .flags_o(fc_i)); // immediate form

	assign fa_normal = ~fa.exp_zero & ~fa.exp_ones; // not zero, subnormal, inf or nan

	// ========================================
	// bit counts and float class
	// ========================================
	always_comb begin : count_bits
		lz = 6'd32; // all clear
		pop = 6'd0;
		for (int i = 0; i < `DATA_W; i++) begin
			if (a_i[i])
				lz = 6'(31 - i); // highest set bit wins
			pop = pop + {5'd0, a_i[i]};
		end
	end

	always_comb begin
		fclass = '0;
		fclass[0] = fa.sign & fa.inf; // -inf
		fclass[1] = fa.sign & fa_normal; // -normal
		fclass[2] = fa.sign & fa.exp_zero & ~fa.val_zero; // -subnormal
		fclass[3] = fa.sign & fa.val_zero; // -0
		fclass[4] = ~fa.sign & fa.val_zero; // +0
		fclass[5] = ~fa.sign & fa.exp_zero & ~fa.val_zero; // +subnormal
		fclass[6] = ~fa.sign & fa_normal; // +normal
		fclass[7] = ~fa.sign & fa.inf; // +inf
		fclass[8] = fa.snan;
		fclass[9] = fa.qnan;
		fclass[31] = fa.sign;
	end

	// ========================================
	// result select
	// ========================================
	always_comb begin : result_mux
		o_o = '0; // undefined codes give zero
		case (ir_i.opcode)
			alu_pkg::R2: begin
				case (ir_i.func)
					alu_pkg::R1: begin
						case (ir_i.rb)
							alu_pkg::CNTLZ: o_o = {26'd0, lz};
							alu_pkg::CNTPOP: o_o = {26'd0, pop};
							alu_pkg::FABS: o_o = {1'b0, a_i[30:0]};
							alu_pkg::FNABS: o_o = {1'b1, a_i[30:0]};
							alu_pkg::FNEG: o_o = {~a_i[31], a_i[30:0]};
							alu_pkg::FCLASS: o_o = fclass;
							alu_pkg::FSIGN: o_o = fa.val_zero ? 32'h0000_0000 :
								fa.sign ? 32'hBF80_0000 : 32'h3F80_0000; // 0.0 / -1.0 / +1.0
							alu_pkg::FFINITE: o_o = b2v(~fa.exp_ones);
							default: o_o = '0;
						endcase
					end
					alu_pkg::ADD: o_o = a_i + b_i;
					alu_pkg::SUB: o_o = a_i - b_i;
					alu_pkg::AND: o_o = a_i & b_i;
					alu_pkg::OR: o_o = a_i | b_i;
					alu_pkg::XOR: o_o = a_i ^ b_i;
					alu_pkg::CMP_EQ: o_o = b2v(a_i == b_i);
					alu_pkg::CMP_NE: o_o = b2v(a_i != b_i);
					alu_pkg::CMP_LT: o_o = b2v($signed(a_i) < $signed(b_i));
					alu_pkg::CMP_GE: o_o = b2v($signed(a_i) >= $signed(b_i));
					alu_pkg::CMP_LE: o_o = b2v($signed(a_i) <= $signed(b_i));
					alu_pkg::CMP_GT: o_o = b2v($signed(a_i) > $signed(b_i));
					alu_pkg::CMP_LTU: o_o = b2v(a_i < b_i);
					alu_pkg::CMP_GEU: o_o = b2v(a_i >= b_i);
					alu_pkg::CMP_LEU: o_o = b2v(a_i <= b_i);
					alu_pkg::CMP_GTU: o_o = b2v(a_i > b_i);
					alu_pkg::FCMP_EQ: o_o = b2v(fc_r.eq);
					alu_pkg::FCMP_NE: o_o = b2v(fc_r.ne); // set on nan
					alu_pkg::FCMP_LT: o_o = b2v(fc_r.lt);
					alu_pkg::FCMP_LE: o_o = b2v(fc_r.le);
					alu_pkg::FCMP_GT: o_o = b2v(fc_r.gt);
					alu_pkg::FCMP_GE: o_o = b2v(fc_r.ge);
					alu_pkg::SLL: o_o = a_i << b_i[4:0];
					alu_pkg::SRL: o_o = a_i >> b_i[4:0];
					alu_pkg::SRA: o_o = $signed(a_i) >>> b_i[4:0]; // sign fill
					alu_pkg::SLLI: o_o = a_i << imm[4:0];
					alu_pkg::SRLI: o_o = a_i >> imm[4:0];
					alu_pkg::SRAI: o_o = $signed(a_i) >>> imm[4:0];
					default: o_o = '0;
				endcase
			end
			alu_pkg::ADDI: o_o = a_i + imm;
			alu_pkg::SUBFI: o_o = imm - a_i; // reverse subtract
			alu_pkg::ANDI: o_o = a_i & imm;
			alu_pkg::ORI: o_o = a_i | imm;
			alu_pkg::XORI: o_o = a_i ^ imm;
			alu_pkg::CMP_EQI: o_o = b2v(a_i == imm);
			alu_pkg::CMP_NEI: o_o = b2v(a_i != imm);
			alu_pkg::CMP_LTI: o_o = b2v($signed(a_i) < $signed(imm));
			alu_pkg::CMP_GEI: o_o = b2v($signed(a_i) >= $signed(imm));
			alu_pkg::CMP_LEI: o_o = b2v($signed(a_i) <= $signed(imm));
			alu_pkg::CMP_GTI: o_o = b2v($signed(a_i) > $signed(imm));
			alu_pkg::CMP_LTUI: o_o = b2v(a_i < imm);
			alu_pkg::CMP_GEUI: o_o = b2v(a_i >= imm);
			alu_pkg::CMP_LEUI: o_o = b2v(a_i <= imm);
			alu_pkg::CMP_GTUI: o_o = b2v(a_i > imm);
			alu_pkg::FCMP_EQI: o_o = b2v(fc_i.eq);
			alu_pkg::FCMP_NEI: o_o = b2v(fc_i.ne);
			alu_pkg::FCMP_LTI: o_o = b2v(fc_i.lt);
			alu_pkg::FCMP_LEI: o_o = b2v(fc_i.le);
			alu_pkg::FCMP_GTI: o_o = b2v(fc_i.gt);
			alu_pkg::FCMP_GEI: o_o = b2v(fc_i.ge);
			alu_pkg::CSR: o_o = csr_i;
			default: o_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "alu_consts.svh"

module reg_file (
	input  wire logic             clk_i,
	input  wire logic [`REG_AW-1:0] ra_i,
	input  wire logic [`REG_AW-1:0] rb_i,
	input  wire logic [`REG_AW-1:0] wa_i,
	input  wire logic             we_i,
	input  alu_pkg::value_t       wd_i,
	output alu_pkg::value_t       a_o,
	output alu_pkg::value_t       b_o
);

	alu_pkg::value_t mem [`NREGS];

	// registers power up cleared
	initial begin
		for (int i = 0; i < `NREGS; i++)
			mem[i] = '0;
	end

	always_ff @(posedge clk_i) begin
		if (we_i && wa_i != '0) // r0 is never stored
			mem[wa_i] <= wd_i;
	end

	assign a_o = (ra_i == '0) ? '0 : mem[ra_i]; // r0 reads zero
	assign b_o = (rb_i == '0) ? '0 : mem[rb_i];

	// the controller keeps r0 writes out of the port
	assert property (@(posedge clk_i) (we_i && wa_i == '0) |-> wd_i == '0);

endmodule

`default_nettype wire

// ==== perf_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "alu_consts.svh"

module perf_counter (
	input  wire logic       clk_i,
	input  wire logic       rst_i,
	input  wire logic       retire_i, // one pulse per completed instruction
	input  wire logic       sel_i,
	output alu_pkg::value_t csr_o
);

	alu_pkg::value_t cycle_q, retired_q;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cycle_q <= '0;
			retired_q <= '0;
		end else begin
			cycle_q <= cycle_q + 1'b1; // wraps
			if (retire_i)
				retired_q <= retired_q + 1'b1;
		end
	end

	always_comb begin
		case (sel_i)
			`CSR_CYCLE: csr_o = cycle_q;
			`CSR_RETIRED: csr_o = retired_q;
			default: csr_o = cycle_q;
		endcase
	end

endmodule

`default_nettype wire

// ==== exec_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "alu_consts.svh"

module exec_ctrl (
	input  wire logic             clk_i,
	input  wire logic             rst_i,
	input  wire logic             issue_i,
	input  wire logic             load_i,
	input  alu_pkg::instr_t       instr_i,
	input  wire logic [`REG_AW-1:0] load_reg_i,
	input  alu_pkg::value_t       alu_res_i,
	output alu_pkg::instr_t       ir_o,
	output logic [`REG_AW-1:0]    rd_a_o,
	output logic [`REG_AW-1:0]    rd_b_o,
	output logic [`REG_AW-1:0]    wr_addr_o,
	output logic                  wr_en_o,
	output logic                  wr_sel_host_o, // 1 = host load data
	output logic                  busy_o,
	output logic                  done_o,
	output alu_pkg::value_t       result_o
);

	alu_pkg::ctrl_state_e state;
	alu_pkg::instr_t ir_q;
	alu_pkg::value_t result_q;
	logic done_q;

	// ========================================
	// sequencer
	// ========================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= alu_pkg::IDLE;
			done_q <= 1'b0;
		end else begin
			case (state)
				alu_pkg::IDLE: if (issue_i) state <= alu_pkg::READ;
				alu_pkg::READ: state <= alu_pkg::EXEC; // operands settle
				alu_pkg::EXEC: state <= alu_pkg::WRITE;
				default: state <= alu_pkg::IDLE; // WRITE retires
			endcase
			done_q <= (state == alu_pkg::EXEC); // pulse lines up with WRITE
		end
	end

	always_ff @(posedge clk_i) begin
		if (issue_i && state == alu_pkg::IDLE)
			ir_q <= instr_i;
		if (state == alu_pkg::EXEC)
			result_q <= alu_res_i; // held until the next done
	end

	// ========================================
	// register file control
	// ========================================
	assign rd_a_o = ir_q.ra;
	assign rd_b_o = ir_q.rb;
	assign wr_sel_host_o = (state == alu_pkg::IDLE); // loads only when idle
	assign wr_addr_o = wr_sel_host_o ? load_reg_i : ir_q.rd;
	assign wr_en_o = (wr_addr_o != '0) &&
		((wr_sel_host_o && load_i) || state == alu_pkg::WRITE); // r0 dropped here

	assign ir_o = ir_q;
	assign busy_o = (state != alu_pkg::IDLE);
	assign done_o = done_q;
	assign result_o = result_q;

	// host must watch busy before a strobe
	assert property (@(posedge clk_i) disable iff (rst_i)
		(issue_i || load_i) |-> state == alu_pkg::IDLE)
		else $error("exec_ctrl: strobe while busy");

	assert property (@(posedge clk_i) disable iff (rst_i)
		done_o |-> state == alu_pkg::WRITE);

endmodule

`default_nettype wire

// ==== exec_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "alu_consts.svh"

module exec_unit (
	input  wire logic             clk_i,
	input  wire logic             rst_i,
	input  wire logic             issue_i,
	input  alu_pkg::instr_t       instr_i,
	input  wire logic             load_i,
	input  wire logic [`REG_AW-1:0] load_reg_i,
	input  alu_pkg::value_t       load_data_i,
	output logic                  busy_o,
	output logic                  done_o,
	output alu_pkg::value_t       result_o
);

	alu_pkg::instr_t ir;
	alu_pkg::value_t opa, opb, wd, alu_res, csr;
	logic [`REG_AW-1:0] rd_a, rd_b, wr_addr;
	logic wr_en, wr_sel_host;

	exec_ctrl u_ctrl (
		.clk_i(clk_i), .rst_i(rst_i), .issue_i(issue_i), .load_i(load_i),
		.instr_i(instr_i), .load_reg_i(load_reg_i), .alu_res_i(alu_res),
		.ir_o(ir), .rd_a_o(rd_a), .rd_b_o(rd_b), .wr_addr_o(wr_addr),
		.wr_en_o(wr_en), .wr_sel_host_o(wr_sel_host),
		.busy_o(busy_o), .done_o(done_o), .result_o(result_o)
	);

	assign wd = wr_sel_host ? load_data_i : result_o; // host load or writeback

	reg_file u_rf (
		.clk_i(clk_i), .ra_i(rd_a), .rb_i(rd_b), .wa_i(wr_addr),
		.we_i(wr_en), .wd_i(wd), .a_o(opa), .b_o(opb)
	);

	perf_counter u_perf (
		.clk_i(clk_i), .rst_i(rst_i), .retire_i(done_o), // retire on done
		.sel_i(ir.imm[0]), .csr_o(csr)
	);

	int_alu u_alu (.ir_i(ir), .a_i(opa), .b_i(opb), .csr_i(csr), .o_o(alu_res));

endmodule

`default_nettype wire

// ==== tb_clkgen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen #(
	parameter int HALF_NS = 10 // 20 ns period
) (
	output logic clk_o
);

	initial clk_o = 1'b0;

	always #(HALF_NS) clk_o = ~clk_o; // free running, never gated

endmodule

`default_nettype wire

// ==== tb_exec_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "alu_consts.svh"

module tb_exec_unit;

	typedef struct {
		bit is_issue; // 0 = host load
		alu_pkg::instr_t instr;
		logic [`REG_AW-1:0] rg; // load target
		alu_pkg::value_t data; // load value
		alu_pkg::value_t exp_val;
		string label;
	} entry_t;

	logic clk, rst_i, issue_i, load_i, busy_o, done_o;
	alu_pkg::instr_t instr_i;
	logic [`REG_AW-1:0] load_reg_i;
	alu_pkg::value_t load_data_i, result_o;

	entry_t tbl[$];
	int n_issue, errors, passes, cycles, cycle_limit;
	logic [31:0] seed;

	tb_clkgen u_clk (.clk_o(clk));

	exec_unit uut (
		.clk_i(clk), .rst_i(rst_i), .issue_i(issue_i), .instr_i(instr_i),
		.load_i(load_i), .load_reg_i(load_reg_i), .load_data_i(load_data_i),
		.busy_o(busy_o), .done_o(done_o), .result_o(result_o)
	);

	// watchdog, limit set once the table is known
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit != 0 && cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, controller in state %s", cycles,
				uut.u_ctrl.state.name());
			$display("Result: FAILED");
			$finish;
		end
	end

	// ========================================
	// table construction
	// ========================================
	function automatic alu_pkg::instr_t r2_instr(input alu_pkg::func_e fn,
			input logic [3:0] rd, input logic [3:0] ra, input logic [3:0] rb);
		alu_pkg::instr_t ir;
		ir = '0;
		ir.opcode = alu_pkg::R2;
		ir.func = fn;
		ir.rd = rd;
		ir.ra = ra;
		ir.rb = rb;
		return ir;
	endfunction

	function automatic alu_pkg::instr_t imm_instr(input alu_pkg::opcode_e op,
			input logic [3:0] rd, input logic [3:0] ra, input logic [7:0] imm);
		alu_pkg::instr_t ir;
		ir = '0;
		ir.opcode = op;
		ir.rd = rd;
		ir.ra = ra;
		ir.imm = imm;
		return ir;
	endfunction

	// single operand op, code rides in rb
	function automatic alu_pkg::instr_t unary_instr(input alu_pkg::r1_e code,
			input logic [3:0] rd, input logic [3:0] ra);
		alu_pkg::instr_t ir;
		ir = '0;
		ir.opcode = alu_pkg::R2;
		ir.func = alu_pkg::R1;
		ir.rb = code;
		ir.rd = rd;
		ir.ra = ra;
		return ir;
	endfunction

	function automatic int count_lead_zeros(input logic [31:0] v);
		int n;
		bit seen;
		n = 0;
		seen = 0;
		for (int i = 31; i >= 0; i--) begin
			if (v[i])
				seen = 1;
			else if (!seen)
				n++; // still above the first one
		end
		return n;
	endfunction

	function automatic int count_ones(input logic [31:0] v);
		int n;
		n = 0;
		foreach (v[i])
			n += int'(v[i]);
		return n;
	endfunction

	// arithmetic shift written as logical shift plus ones on top
	function automatic logic [31:0] sign_fill_shift(input logic [31:0] v, input int sh);
		return (v >> sh) | (v[31] ? ~(32'hFFFF_FFFF >> sh) : 32'h0);
	endfunction

	task automatic load_entry(input logic [3:0] rg, input alu_pkg::value_t data);
		entry_t e;
		e.is_issue = 0;
		e.instr = '0;
		e.rg = rg;
		e.data = data;
		e.exp_val = '0;
		e.label = "load";
		tbl.push_back(e);
	endtask

	task automatic issue_entry(input string label, input alu_pkg::instr_t ir,
			input alu_pkg::value_t exp_val);
		entry_t e;
		e.is_issue = 1;
		e.instr = ir;
		e.rg = '0;
		e.data = '0;
		e.exp_val = exp_val;
		e.label = label;
		tbl.push_back(e);
		n_issue++; // instructions retired before the next one
	endtask

	task automatic build_table();
		alu_pkg::value_t x, y, n, z;
		int sh;
		x = $urandom;
		y = $urandom;
		n = $urandom | 32'h8000_0000; // negative for sra
		sh = $urandom_range(31, 1);
		z = $urandom >> $urandom_range(31, 0); // spread the leading zeros
		load_entry(1, x);
		load_entry(2, y);
		load_entry(3, n);
		load_entry(4, sh);
		issue_entry("ADD", r2_instr(alu_pkg::ADD, 5, 1, 2), x + y);
		issue_entry("SUB", r2_instr(alu_pkg::SUB, 5, 1, 2), x - y);
		issue_entry("AND", r2_instr(alu_pkg::AND, 5, 1, 2), x & y);
		issue_entry("OR", r2_instr(alu_pkg::OR, 5, 1, 2), x | y);
		issue_entry("XOR", r2_instr(alu_pkg::XOR, 5, 1, 2), x ^ y);
		issue_entry("ADDI", imm_instr(alu_pkg::ADDI, 6, 1, 8'hFB), x - 32'd5);
		issue_entry("SUBFI", imm_instr(alu_pkg::SUBFI, 6, 1, 8'hEC), -32'd20 - x);
		issue_entry("SLL", r2_instr(alu_pkg::SLL, 6, 1, 4), x << sh);
		issue_entry("SRL", r2_instr(alu_pkg::SRL, 6, 1, 4), x >> sh);
		issue_entry("SRA", r2_instr(alu_pkg::SRA, 6, 3, 4), sign_fill_shift(n, sh));
		// ========================================
		// signed against unsigned on -1 and 1
		// ========================================
		load_entry(7, 32'hFFFF_FFFF);
		load_entry(8, 32'd1);
		issue_entry("CMP_LT", r2_instr(alu_pkg::CMP_LT, 5, 7, 8), 32'd1);
		issue_entry("CMP_LTU", r2_instr(alu_pkg::CMP_LTU, 5, 7, 8), 32'd0);
		issue_entry("CMP_GTU", r2_instr(alu_pkg::CMP_GTU, 5, 7, 8), 32'd1);
		issue_entry("CMP_LTI", imm_instr(alu_pkg::CMP_LTI, 5, 7, 8'd1), 32'd1);
		issue_entry("CMP_LTUI", imm_instr(alu_pkg::CMP_LTUI, 5, 7, 8'd1), 32'd0);
		issue_entry("CMP_GTUI", imm_instr(alu_pkg::CMP_GTUI, 5, 7, 8'd1), 32'd1);
		load_entry(9, z);
		issue_entry("CNTLZ", unary_instr(alu_pkg::CNTLZ, 5, 9), count_lead_zeros(z));
		issue_entry("CNTPOP", unary_instr(alu_pkg::CNTPOP, 5, 9), count_ones(z));
		issue_entry("FABS", unary_instr(alu_pkg::FABS, 5, 9), z & 32'h7FFF_FFFF);
		issue_entry("FNABS", unary_instr(alu_pkg::FNABS, 5, 9), z | 32'h8000_0000);
		issue_entry("FNEG", unary_instr(alu_pkg::FNEG, 5, 9), z ^ 32'h8000_0000);
		load_entry(10, 32'hC020_0000); // -2.5
		load_entry(11, 32'h40E0_0000); // 7.0
		issue_entry("FSIGN-", unary_instr(alu_pkg::FSIGN, 5, 10), 32'hBF80_0000);
		issue_entry("FSIGN0", unary_instr(alu_pkg::FSIGN, 5, 0), 32'h0000_0000);
		issue_entry("FSIGN+", unary_instr(alu_pkg::FSIGN, 5, 11), 32'h3F80_0000);
		// ========================================
		// float class and nan compares
		// ========================================
		load_entry(12, 32'hFF80_0000); // -inf
		load_entry(13, 32'h0000_0001); // smallest +subnormal
		load_entry(14, 32'h7F80_0001); // snan, quiet bit clear
		load_entry(15, 32'h7FC0_0000); // qnan
		issue_entry("FCLASS", unary_instr(alu_pkg::FCLASS, 5, 12), 32'h8000_0001);
		issue_entry("FCLASS", unary_instr(alu_pkg::FCLASS, 5, 0), 32'h0000_0010);
		issue_entry("FCLASS", unary_instr(alu_pkg::FCLASS, 5, 13), 32'h0000_0020);
		issue_entry("FCLASS", unary_instr(alu_pkg::FCLASS, 5, 14), 32'h0000_0100);
		issue_entry("FCLASS", unary_instr(alu_pkg::FCLASS, 5, 15), 32'h0000_0200);
		issue_entry("FCLASS", unary_instr(alu_pkg::FCLASS, 5, 10), 32'h8000_0002); // -normal
		issue_entry("FCMP_EQ", r2_instr(alu_pkg::FCMP_EQ, 5, 15, 11), 32'd0);
		issue_entry("FCMP_LT", r2_instr(alu_pkg::FCMP_LT, 5, 15, 11), 32'd0);
		issue_entry("FCMP_LE", r2_instr(alu_pkg::FCMP_LE, 5, 15, 11), 32'd0);
		issue_entry("FCMP_GT", r2_instr(alu_pkg::FCMP_GT, 5, 15, 11), 32'd0);
		issue_entry("FCMP_GE", r2_instr(alu_pkg::FCMP_GE, 5, 15, 11), 32'd0);
		issue_entry("FCMP_NE", r2_instr(alu_pkg::FCMP_NE, 5, 15, 11), 32'd1);
		load_entry(2, 32'h8000_0000); // -0
		issue_entry("FCMP_EQ", r2_instr(alu_pkg::FCMP_EQ, 5, 0, 2), 32'd1);
		// csr sees every issue queued so far as retired
		issue_entry("CSR", imm_instr(alu_pkg::CSR, 5, 0, 8'd1), n_issue);
		issue_entry("ADDI", imm_instr(alu_pkg::ADDI, 6, 5, 8'd0), n_issue - 1);
		issue_entry("ADD_R0", r2_instr(alu_pkg::ADD, 0, 1, 1), x + x); // dropped write
		issue_entry("ADDI", imm_instr(alu_pkg::ADDI, 6, 0, 8'd0), 32'd0);
	endtask

	// ========================================
	// entry drivers, called just after a falling edge
	// ========================================
	task automatic run_load(input entry_t e);
		load_i = 1'b1;
		load_reg_i = e.rg;
		load_data_i = e.data;
		@(negedge clk);
		load_i = 1'b0;
		passes++;
		$display("load r%0d <= %h", e.rg, e.data);
	endtask

	task automatic run_issue(input entry_t e);
		int lat;
		bit ok;
		issue_i = 1'b1;
		instr_i = e.instr;
		ok = 1;
		lat = 0;
		do begin // watchdog bounds this
			@(negedge clk);
			issue_i = 1'b0;
			lat++;
			assert (busy_o) else begin
				$display("Error: time %0t signal busy_o expected 1 actual %b",
					$time, busy_o);
				ok = 0;
			end
		end while (!done_o);
		assert (lat == 3) else begin
			$display("Error: time %0t signal done_o latency expected 3 actual %0d", $time, lat);
			ok = 0;
		end
		assert (result_o == e.exp_val) else begin
			$display("Error: time %0t signal result_o expected %h actual %h",
				$time, e.exp_val, result_o);
			ok = 0;
		end
		@(negedge clk); // writeback edge, back to idle
		assert (!done_o) else begin // single cycle pulse
			$display("Error: time %0t signal done_o expected 0 actual %b", $time, done_o);
			ok = 0;
		end
		if (ok)
			passes++;
		else
			errors++;
		$display("issue %-8s res=%h %s", e.label, result_o, ok ? "ok" : "mismatch");
	endtask

	initial begin
		rst_i = 1'b1;
		issue_i = 1'b0;
		load_i = 1'b0;
		instr_i = '0;
		load_reg_i = '0;
		load_data_i = '0;
		errors = 0;
		passes = 0;
		n_issue = 0;
		cycles = 0;
		cycle_limit = 0;
		seed = 32'h4cc;
		void'($urandom(seed));
		build_table();
		cycle_limit = tbl.size() * 8 + 50;
		repeat (5) @(negedge clk);
		rst_i = 1'b0;
		assert (!done_o) else begin
			$display("Error: time %0t signal done_o expected 0 actual %b", $time, done_o);
			errors++;
		end
		foreach (tbl[i]) begin
			assert (!busy_o) else begin
				$display("Error: time %0t signal busy_o expected 0 actual %b", $time, busy_o);
				errors++;
			end
			if (tbl[i].is_issue)
				run_issue(tbl[i]);
			else
				run_load(tbl[i]);
		end
		$display("entries %0d passed %0d errors %0d", tbl.size(), passes, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
alu_pkg.sv
fp_decomp.sv
fp_compare.sv
int_alu.sv
reg_file.sv
perf_counter.sv
exec_ctrl.sv
exec_unit.sv
tb_clkgen.sv
tb_exec_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module tb_exec_unit -o sim_exec_unit
./obj_dir/sim_exec_unit 2>&1 | tee sim.log

if grep -q "Result: PASSED" sim.log; then
	echo "simulation ok"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
